// File: rtl/ctrlProtocolPkg.sv
`default_nettype none

package ctrlProtocolPkg;

    typedef logic [7:0] byte_t;

    // Command frame is an opcode followed by three data bytes
    localparam int FrameBytes      = 4;
    localparam int FrameCountWidth = $clog2(FrameBytes);

    // Reply carries its own size in the first byte
    localparam int ReplyBytes      = 5;
    localparam int ReplyIdxWidth   = $clog2(ReplyBytes);

    localparam byte_t OpVersion = 8'h00;       // Read firmware version

    // Upper opcode nibbles, the low nibble picks the channel
    localparam logic [3:0] OpStartHi    = 4'hA;  // PWM start
    localparam logic [3:0] OpStopHi     = 4'hB;  // PWM stop
    localparam logic [3:0] OpConfigHi   = 4'hC;  // PWM period and tOn
    localparam logic [3:0] OpLedOnHi    = 4'hD;  // LED full on
    localparam logic [3:0] OpLedOffHi   = 4'hE;  // LED off
    localparam logic [3:0] OpLedLevelHi = 4'hF;  // LED brightness from D0

    // Reply type byte for the version read
    localparam byte_t VersionTag = 8'd0;

    // Firmware identification
    localparam byte_t FirmwareVersion = 8'd6;
    localparam byte_t FirmwareYear    = 8'd12;
    localparam byte_t FirmwareMonth   = 8'd7;

endpackage

`default_nettype wire

// File: rtl/ctrlTimingPkg.sv
`default_nettype none

package ctrlTimingPkg;

    localparam int Channels = 4;                  // PWM channels and LED dimmers

    typedef logic [$clog2(Channels)-1:0] chanIdx_t;

    localparam int PeriodWidth = 16;
    localparam int DutyWidth   = 8;

    // Microsecond tick derived from clk
    localparam int TickDivide = 16;
    localparam int TickWidth  = $clog2(TickDivide);

    // Ticks of silence before a partial frame is dropped
    localparam int TimeoutTicks = 2047;
    localparam int TimeoutWidth = $clog2(TimeoutTicks + 1);

    // Reply stream credits, also the ceiling
    localparam int ReplyCredits = 4;
    localparam int CreditWidth  = $clog2(ReplyCredits + 1);

    localparam logic [PeriodWidth-1:0] PwmResetPeriod = PeriodWidth'(65535);

endpackage

`default_nettype wire

// File: rtl/frameReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module frameReceiver
    import ctrlProtocolPkg::*, ctrlTimingPkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        tick,
    input  wire        rxValid,
    input  wire byte_t rxByte,
    output logic       frameValid,
    output byte_t      frameOp,
    output byte_t      frameD0,
    output byte_t      frameD1,
    output byte_t      frameD2
);

    logic [FrameCountWidth-1:0] byteCount;    // Bytes of current frame so far
    logic [TimeoutWidth-1:0]    idleTicks;    // Ticks since last byte
    logic                       lastByte;
    logic                       idleExpired;

    assign lastByte    = byteCount == FrameCountWidth'(FrameBytes - 1);
    assign idleExpired = idleTicks == TimeoutWidth'(TimeoutTicks - 1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            byteCount  <= '0;
            idleTicks  <= '0;
            frameValid <= 1'b0;
        end
        else
        begin
            frameValid <= 1'b0;
            if (rxValid)
            begin
                idleTicks <= '0;
                if (lastByte)
                begin
                    byteCount  <= '0;
                    frameValid <= 1'b1;    // Frame complete
                end
                else
                begin
                    byteCount <= byteCount + 1'b1;
                end
            end
            else if (tick && byteCount != '0)
            begin
                if (idleExpired)
                begin
                    byteCount <= '0;       // Throw away partial frame
                    idleTicks <= '0;
                end
                else
                begin
                    idleTicks <= idleTicks + 1'b1;
                end
            end
        end
    end

    // Frame buffer
    always_ff @(posedge clk)
    begin
        if (rxValid)
        begin
            case (byteCount)
                0:       frameOp <= rxByte;
                1:       frameD0 <= rxByte;
                2:       frameD1 <= rxByte;
                default: frameD2 <= rxByte;
            endcase
        end
    end

    // Frames need four separate bytes, so pulses can never touch
    assert property (@(posedge clk) disable iff (rst) frameValid |=> !frameValid);

endmodule

`default_nettype wire

// File: rtl/commandDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module commandDecoder
    import ctrlProtocolPkg::*, ctrlTimingPkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  frameValid,
    input  wire byte_t                           frameOp,
    input  wire byte_t                           frameD0,
    input  wire byte_t                           frameD1,
    input  wire byte_t                           frameD2,
    input  wire                                  replyBusy,
    output logic                                 replyStart,
    output logic [Channels-1:0][PeriodWidth-1:0] chanPeriod,
    output logic [Channels-1:0][DutyWidth-1:0]   chanDuty,
    output logic [Channels-1:0]                  chanEnable,
    output logic [Channels-1:0]                  chanRestart,
    output byte_t [Channels-1:0]                 ledLevel
);

    logic [3:0] opHi;       // Command class
    logic [3:0] opLo;       // Channel number as sent
    chanIdx_t   chan;
    logic       chanOk;     // Channel exists

    assign opHi   = frameOp[7:4];
    assign opLo   = frameOp[3:0];
    assign chan   = chanIdx_t'(opLo);
    assign chanOk = opLo < Channels;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            replyStart  <= 1'b0;
            chanPeriod  <= {Channels{PwmResetPeriod}};
            chanDuty    <= '0;
            chanEnable  <= '0;
            chanRestart <= '0;
            ledLevel    <= '0;
        end
        else
        begin
            replyStart  <= 1'b0;
            chanRestart <= '0;
            if (frameValid)
            begin
                if (frameOp == OpVersion)
                begin
                    replyStart <= !replyBusy;    // Dropped while a reply is out
                end
                else if (chanOk)
                begin
                    case (opHi)
                        OpStartHi:
                        begin
                            chanEnable[chan]  <= 1'b1;
                            chanRestart[chan] <= 1'b1;    // Counter back to zero
                        end
                        OpStopHi:
                        begin
                            chanEnable[chan] <= 1'b0;
                        end
                        OpConfigHi:
                        begin
                            chanPeriod[chan] <= {frameD0, frameD1};
                            chanDuty[chan]   <= frameD2;
                        end
                        OpLedOnHi:
                        begin
                            ledLevel[chan] <= 8'd255;
                        end
                        OpLedOffHi:
                        begin
                            ledLevel[chan] <= 8'd0;
                        end
                        OpLedLevelHi:
                        begin
                            ledLevel[chan] <= frameD0;
                        end
                        default:
                        begin
                            // Unknown command is ignored
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pwmBank.sv
`timescale 1ns/1ps
`default_nettype none

module pwmBank
    import ctrlProtocolPkg::*, ctrlTimingPkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [Channels-1:0][PeriodWidth-1:0] chanPeriod,
    input  wire [Channels-1:0][DutyWidth-1:0]   chanDuty,
    input  wire [Channels-1:0]                  chanEnable,
    input  wire [Channels-1:0]                  chanRestart,
    input  wire byte_t [Channels-1:0]           ledLevel,
    output logic                                tick,
    output logic [Channels-1:0]                 pwmOut,
    output logic [Channels-1:0]                 ledOut
);

    logic [TickWidth-1:0]                 tickCount;
    logic [Channels-1:0][PeriodWidth-1:0] chanCount;    // Position within period
    byte_t                                ledCount;     // Shared dimmer phase

    assign tick = tickCount == TickWidth'(TickDivide - 1);

    always_ff @(posedge clk)
    begin
        if (rst)
            tickCount <= '0;
        else if (tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            chanCount <= '0;
            pwmOut    <= '0;
        end
        else
        begin
            for (int ch = 0; ch < Channels; ch++)
            begin
                // Also catches a period shortened below the count
                if (chanRestart[ch] || chanCount[ch] >= chanPeriod[ch])
                    chanCount[ch] <= '0;
                else if (tick)
                    chanCount[ch] <= (chanCount[ch] == chanPeriod[ch] - 1'b1) ?
                                     '0 : chanCount[ch] + 1'b1;
                pwmOut[ch] <= chanEnable[ch] && (chanCount[ch] < PeriodWidth'(chanDuty[ch]));
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ledCount <= '0;
            ledOut   <= '0;
        end
        else
        begin
            if (tick)
                ledCount <= ledCount + 1'b1;    // Wraps at 256
            for (int led = 0; led < Channels; led++)
                ledOut[led] <= ledCount < ledLevel[led];
        end
    end

    // Count stays inside the period one cycle after any period change
    for (genvar ch = 0; ch < Channels; ch++)
    begin : gPeriodCheck
        assert property (@(posedge clk) disable iff (rst)
            (chanPeriod[ch] != '0 && $stable(chanPeriod[ch])) |->
                chanCount[ch] < chanPeriod[ch]);
    end

endmodule

`default_nettype wire

// File: rtl/replySender.sv
`timescale 1ns/1ps
`default_nettype none

module replySender
    import ctrlProtocolPkg::*, ctrlTimingPkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   replyStart,
    input  wire   replyCredit,
    output logic  replyBusy,
    output logic  replyValid,
    output byte_t replyByte
);

    logic [ReplyIdxWidth-1:0] byteIdx;    // Next reply byte
    logic [CreditWidth-1:0]   credits;    // Bytes the receiver can still take
    logic                     sendNow;
    byte_t                    nextByte;

    // First byte may go out right on the request
    assign sendNow = (replyStart || replyBusy) && credits != '0;

    always_comb
    begin
        case (byteIdx)
            0:       nextByte = byte_t'(ReplyBytes - 1);    // Size byte
            1:       nextByte = VersionTag;
            2:       nextByte = FirmwareVersion;
            3:       nextByte = FirmwareYear;
            default: nextByte = FirmwareMonth;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            replyBusy  <= 1'b0;
            replyValid <= 1'b0;
            byteIdx    <= '0;
            credits    <= CreditWidth'(ReplyCredits);
        end
        else
        begin
            replyValid <= sendNow;
            credits    <= credits - CreditWidth'(sendNow) + CreditWidth'(replyCredit);
            if (sendNow)
            begin
                if (byteIdx == ReplyIdxWidth'(ReplyBytes - 1))
                begin
                    byteIdx   <= '0;
                    replyBusy <= 1'b0;    // Last byte leaves now
                end
                else
                begin
                    byteIdx   <= byteIdx + 1'b1;
                    replyBusy <= 1'b1;
                end
            end
            else if (replyStart)
            begin
                replyBusy <= 1'b1;        // Waiting for credits
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sendNow)
            replyByte <= nextByte;
    end

    assert property (@(posedge clk) disable iff (rst) replyValid |-> $past(credits) != '0);

    // Receiver may not return more than it was given
    assert property (@(posedge clk) disable iff (rst)
        replyCredit |-> credits != CreditWidth'(ReplyCredits));

endmodule

`default_nettype wire

// File: rtl/pwmController.sv
`timescale 1ns/1ps
`default_nettype none

module pwmController
    import ctrlProtocolPkg::*, ctrlTimingPkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rxValid,
    input  wire byte_t          rxByte,
    input  wire                 replyCredit,
    output logic                replyValid,
    output byte_t               replyByte,
    output logic [Channels-1:0] pwmOut,
    output logic [Channels-1:0] ledOut
);

    logic                                 tick;         // Microsecond pace
    logic                                 frameValid;
    byte_t                                frameOp;
    byte_t                                frameD0;
    byte_t                                frameD1;
    byte_t                                frameD2;
    logic                                 replyStart;
    logic                                 replyBusy;
    logic [Channels-1:0][PeriodWidth-1:0] chanPeriod;
    logic [Channels-1:0][DutyWidth-1:0]   chanDuty;
    logic [Channels-1:0]                  chanEnable;
    logic [Channels-1:0]                  chanRestart;
    byte_t [Channels-1:0]                 ledLevel;

    frameReceiver i_frameReceiver (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .rxValid    (rxValid),
        .rxByte     (rxByte),
        .frameValid (frameValid),
        .frameOp    (frameOp),
        .frameD0    (frameD0),
        .frameD1    (frameD1),
        .frameD2    (frameD2)
    );

    commandDecoder i_commandDecoder (
        .clk         (clk),
        .rst         (rst),
        .frameValid  (frameValid),
        .frameOp     (frameOp),
        .frameD0     (frameD0),
        .frameD1     (frameD1),
        .frameD2     (frameD2),
        .replyBusy   (replyBusy),
        .replyStart  (replyStart),
        .chanPeriod  (chanPeriod),
        .chanDuty    (chanDuty),
        .chanEnable  (chanEnable),
        .chanRestart (chanRestart),
        .ledLevel    (ledLevel)
    );

    pwmBank i_pwmBank (
        .clk         (clk),
        .rst         (rst),
        .chanPeriod  (chanPeriod),
        .chanDuty    (chanDuty),
        .chanEnable  (chanEnable),
        .chanRestart (chanRestart),
        .ledLevel    (ledLevel),
        .tick        (tick),
        .pwmOut      (pwmOut),
        .ledOut      (ledOut)
    );

    replySender i_replySender (
        .clk         (clk),
        .rst         (rst),
        .replyStart  (replyStart),
        .replyCredit (replyCredit),
        .replyBusy   (replyBusy),
        .replyValid  (replyValid),
        .replyByte   (replyByte)
    );

endmodule

`default_nettype wire

// File: test/pwmControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module pwmControllerTb
    import ctrlProtocolPkg::*, ctrlTimingPkg::*;
();

    logic                clk;
    logic                rst;
    logic                rxValid;
    byte_t               rxByte;
    logic                replyCredit;
    logic                replyValid;
    byte_t               replyByte;
    logic [Channels-1:0] pwmOut;
    logic [Channels-1:0] ledOut;

    int          errors;
    logic [31:0] seed;
    byte_t       expReply[$];           // Reply bytes still to come
    int          credits;               // Receiver side view of the credit count
    int          creditDelay;
    logic        holdCredits;
    logic        nextCredit;
    int          modelPeriod[Channels];
    int          modelDuty[Channels];
    logic        modelEnable[Channels];
    int          modelLevel[Channels];

    pwmController i_pwmController (
        .clk         (clk),
        .rst         (rst),
        .rxValid     (rxValid),
        .rxByte      (rxByte),
        .replyCredit (replyCredit),
        .replyValid  (replyValid),
        .replyByte   (replyByte),
        .pwmOut      (pwmOut),
        .ledOut      (ledOut)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;                // Low bits of an LCG repeat quickly
    endfunction

    function automatic int randomRange(input int low, input int high);
        return low + int'(nextRandom() % (high - low + 1));
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    // Reply monitor and credit return, sampled 1 ns after the edge
    always @(posedge clk)
    begin
        #1;
        nextCredit = 1'b0;
        if (rst)
        begin
            credits     = ReplyCredits;
            creditDelay = 0;
        end
        else
        begin
            if (replyValid)
            begin
                if (credits == 0)
                begin
                    $display("Reply byte sent while the receiver held no credit");
                    errors++;
                end
                else
                    credits--;
                if (expReply.size() == 0)
                begin
                    $display("Unexpected reply byte 0x%02h", replyByte);
                    errors++;
                end
                else
                    checkValue("replyByte", replyByte, expReply.pop_front());
            end
            if (replyCredit)
                credits++;
            if (creditDelay > 0)
                creditDelay--;
            else if (credits < ReplyCredits && !holdCredits)
            begin
                nextCredit  = 1'b1;
                creditDelay = randomRange(0, 20);
            end
        end
        #1;
        replyCredit = nextCredit;
    end

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic sendByte(input byte_t value);
        int gap;
        gap = randomRange(0, 3);
        repeat (gap) stepCycle();
        rxValid = 1'b1;
        rxByte  = value;
        stepCycle();
        rxValid = 1'b0;
    endtask

    // Expected effect of one frame on the outputs and replies
    task automatic updateModel(input byte_t op, input byte_t d0, input byte_t d1,
                               input byte_t d2);
        int ch;
        ch = op[3:0];
        if (op == 8'h00)
        begin
            expReply.push_back(8'd4);    // Size byte
            expReply.push_back(8'd0);
            expReply.push_back(8'd6);
            expReply.push_back(8'd12);
            expReply.push_back(8'd7);
        end
        else if (ch < Channels)
        begin
            case (op[7:4])
                4'hA: modelEnable[ch] = 1'b1;
                4'hB: modelEnable[ch] = 1'b0;
                4'hC:
                begin
                    modelPeriod[ch] = {d0, d1};
                    modelDuty[ch]   = d2;
                end
                4'hD: modelLevel[ch] = 255;
                4'hE: modelLevel[ch] = 0;
                4'hF: modelLevel[ch] = d0;
                default: ;
            endcase
        end
    endtask

    task automatic sendCommand(input byte_t op, input byte_t d0, input byte_t d1,
                               input byte_t d2);
        updateModel(op, d0, d1, d2);
        sendByte(op);
        sendByte(d0);
        sendByte(d1);
        sendByte(d2);
        repeat (3) stepCycle();          // Registers settle
    endtask

    task automatic waitReplyDone();
        int waited;
        waited = 0;
        while (expReply.size() != 0 && waited < 2000)
        begin
            stepCycle();
            waited++;
        end
        if (expReply.size() != 0)
        begin
            $display("Timed out waiting for the reply, %0d bytes missing", expReply.size());
            errors++;
            expReply.delete();
        end
    endtask

    task automatic waitCreditsFull();
        int waited;
        waited = 0;
        while (credits != ReplyCredits && waited < 500)
        begin
            stepCycle();
            waited++;
        end
        if (credits != ReplyCredits)
        begin
            $display("Timed out waiting for all reply credits to return");
            errors++;
        end
    endtask

    // Output is periodic, so any whole number of periods gives the same count
    task automatic checkPwm(input int ch);
        int highs;
        int window;
        int expected;
        window   = 2000;                 // Disabled channel must stay low
        expected = 0;
        if (modelEnable[ch])
        begin
            window   = 3 * modelPeriod[ch] * TickDivide;
            expected = modelDuty[ch] < modelPeriod[ch] ? modelDuty[ch] : modelPeriod[ch];
            expected = 3 * expected * TickDivide;
        end
        highs = 0;
        repeat (window)
        begin
            stepCycle();
            highs += pwmOut[ch];
        end
        checkValue($sformatf("pwmOut[%0d] high cycles", ch), highs, expected);
    endtask

    task automatic checkLeds();
        int highs[Channels];
        for (int led = 0; led < Channels; led++)
            highs[led] = 0;
        repeat (256 * TickDivide)        // One full dimmer cycle
        begin
            stepCycle();
            for (int led = 0; led < Channels; led++)
                highs[led] += ledOut[led];
        end
        for (int led = 0; led < Channels; led++)
            checkValue($sformatf("ledOut[%0d] high cycles", led), highs[led],
                       modelLevel[led] * TickDivide);
    endtask

    task automatic exercisePwm(input int ch);
        int period;
        period = randomRange(4, 20);
        sendCommand(byte_t'(8'hC0 + ch), byte_t'(period >> 8), byte_t'(period),
                    byte_t'(randomRange(0, 24)));
        sendCommand(byte_t'(8'hA0 + ch), byte_t'(randomRange(0, 255)), 8'h00, 8'h00);
        repeat (400) stepCycle();
        checkPwm(ch);
    endtask

    initial
    begin
        errors      = 0;
        seed        = 32'h91c9;
        holdCredits = 1'b0;
        clk         = 1'b0;
        rst         = 1'b1;
        rxValid     = 1'b0;
        rxByte      = '0;
        replyCredit = 1'b0;
        for (int ch = 0; ch < Channels; ch++)
        begin
            modelPeriod[ch] = 65535;
            modelDuty[ch]   = 0;
            modelEnable[ch] = 1'b0;
            modelLevel[ch]  = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        checkValue("replyValid", replyValid, 0);
        checkValue("pwmOut", pwmOut, 0);
        checkValue("ledOut", ledOut, 0);

        repeat (3)
        begin
            sendCommand(8'h00, byte_t'(randomRange(0, 255)), 8'h00, 8'h00);
            waitReplyDone();
        end

        // Four bytes go out on the initial credits, the fifth must wait
        waitCreditsFull();
        holdCredits = 1'b1;
        sendCommand(8'h00, 8'h00, 8'h00, 8'h00);
        repeat (100) stepCycle();
        checkValue("pending reply bytes", expReply.size(), 1);
        holdCredits = 1'b0;
        waitReplyDone();

        for (int ch = 0; ch < Channels; ch++)
            exercisePwm(ch);
        repeat (4) exercisePwm(randomRange(0, Channels - 1));

        sendCommand(byte_t'(8'hB0 + randomRange(0, Channels - 1)), 8'h00, 8'h00, 8'h00);
        for (int ch = 0; ch < Channels; ch++)
            checkPwm(ch);

        repeat (2)
        begin
            for (int led = 0; led < Channels; led++)
                sendCommand(byte_t'(8'hD0 + 8'h10 * randomRange(0, 2) + led),
                            byte_t'(randomRange(0, 255)), 8'h00, 8'h00);
            checkLeds();
        end

        // Partial frame must be dropped after the inactivity timeout
        sendByte(8'hC1);
        sendByte(8'h00);
        repeat (34000) stepCycle();
        sendCommand(8'h00, 8'h00, 8'h00, 8'h00);
        waitReplyDone();

        sendCommand(8'h35, byte_t'(randomRange(0, 255)), 8'h00, 8'h10);
        sendCommand(8'h01, 8'h00, 8'h00, 8'h00);
        sendCommand(8'hA7, 8'h00, 8'h00, 8'h00);
        sendCommand(8'hC7, 8'h00, 8'h08, 8'h04);
        sendCommand(8'hF7, byte_t'(randomRange(0, 255)), 8'h00, 8'h00);
        repeat (50) stepCycle();
        for (int ch = 0; ch < Channels; ch++)
            checkPwm(ch);
        checkLeds();

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: pwmController.f
rtl/ctrlProtocolPkg.sv
rtl/ctrlTimingPkg.sv
rtl/frameReceiver.sv
rtl/commandDecoder.sv
rtl/pwmBank.sv
rtl/replySender.sv
rtl/pwmController.sv
test/pwmControllerTb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module pwmControllerTb -f pwmController.f

output=$(./obj_dir/VpwmControllerTb)
echo "$output"
echo "$output" | grep -q "^TEST OK$"
